// ==== verilog.f ====
hw/decodePkg.sv
hw/pipeStage.sv
hw/registerFile.sv
hw/controller.sv
hw/instructionDecodeUnit.sv
hw/decodeStage.sv
tb/decodeStage_assert.sv
tb/decodeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module decodeStageTb \
    -f verilog.f \
    -o decodeStageSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/decodeStageSim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

exit 0

// ==== tb/decodeStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;

    import decodePkg::*;

    logic        Clk;
    logic        rstN;
    logic        inValid;
    logic [31:0] inInstruction;
    logic [31:0] inPc;
    logic        inReady;
    logic        wbRegWrite;
    logic [4:0]  wbDest;
    logic [31:0] wbData;
    logic        outReady;
    logic        outValid;
    logic [31:0] outPc;
    logic [31:0] outJumpTarget;
    logic [31:0] outReadData1;
    logic [31:0] outReadData2;
    logic [31:0] outImmediate;
    logic [4:0]  outShamt;
    logic [4:0]  outDest;
    aluOpT       outAluOp;
    logic        outAluSrc;
    logic        outBranch;
    logic        outNotZero;
    jumpT        outJump;
    logic        outMemRead;
    logic        outMemWrite;
    logic        outMemToReg;
    logic        outRegWrite;
    logic        outIllegal;

    // Reference state mirroring the register file and both pipeline slots
    logic [31:0]  modelRegs [32];
    decodePacketT expQueue [$];
    logic         ifIdValidM;
    logic [31:0]  ifIdInstrM;
    logic [31:0]  ifIdPcM;
    logic         idExValidM;
    int           sentCount;
    int           recvCount;

    decodeStage i_decodeStage (.*);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Error reporting and comparison
    ////////////////////////////////////////////////////////////////////////////

    task automatic stopRun();
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic reportFailure(input string msg);
        $display("Error at %0t: %s", $time, msg);
        stopRun();
    endtask

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stopRun();
        end
    endtask

    // Decode table written as one condition per control
    function automatic decodePacketT modelDecode(input logic [31:0] instr,
                                                 input logic [31:0] pc);
        decodePacketT p;
        logic [5:0]   op;
        logic [5:0]   fn;
        logic         aluR;
        logic         isJr;
        logic         aluI;
        logic         zext;
        op   = instr[31:26];
        fn   = instr[5:0];
        aluR = (op == opRType) &&
               (fn inside {fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSll, fnSrl});
        isJr = (op == opRType) && (fn == fnJr);
        aluI = op inside {opAddiu, opSlti, opAndi, opOri, opXori, opLui};
        zext = op inside {opAndi, opOri, opXori, opLui};
        p            = '0;
        p.pc         = pc;
        p.jumpTarget = {pc[31:28], instr[25:0], 2'b00};
        p.readData1  = modelRegs[instr[25:21]];
        p.readData2  = modelRegs[instr[20:16]];
        p.immediate  = zext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
        p.shamt      = instr[10:6];
        p.regWrite   = aluR || aluI || (op == opLw) || (op == opJal);
        p.aluSrc     = aluI || (op == opLw) || (op == opSw);
        p.branch     = op inside {opBeq, opBne};
        p.notZero    = (op == opBne);
        p.memRead    = (op == opLw);
        p.memToReg   = (op == opLw);
        p.memWrite   = (op == opSw);
        p.illegal    = !(aluR || isJr || aluI || op inside {opLw, opSw, opBeq, opBne, opJ, opJal});
        if (op inside {opJ, opJal}) p.jump = jumpDirect;
        else if (isJr) p.jump = jumpReg;
        if (aluR) p.dest = instr[15:11];
        else if (aluI || op == opLw) p.dest = instr[20:16];
        else if (op == opJal) p.dest = linkReg;
        if ((op inside {opBeq, opBne}) || (aluR && fn == fnSubu)) p.aluOp = aluSub;
        else if (op == opLui) p.aluOp = aluLui;
        else if ((aluR && fn == fnAnd) || op == opAndi) p.aluOp = aluAnd;
        else if ((aluR && fn == fnOr) || op == opOri) p.aluOp = aluOr;
        else if ((aluR && fn == fnXor) || op == opXori) p.aluOp = aluXor;
        else if ((aluR && fn == fnSlt) || op == opSlti) p.aluOp = aluSlt;
        else if (aluR && fn == fnSll) p.aluOp = aluSll;
        else if (aluR && fn == fnSrl) p.aluOp = aluSrl;
        return p;
    endfunction

    task automatic comparePacket(input decodePacketT e);
        checkField("outPc", outPc, e.pc);
        checkField("outJumpTarget", outJumpTarget, e.jumpTarget);
        checkField("outReadData1", outReadData1, e.readData1);
        checkField("outReadData2", outReadData2, e.readData2);
        checkField("outImmediate", outImmediate, e.immediate);
        checkField("outShamt", 32'(outShamt), 32'(e.shamt));
        checkField("outDest", 32'(outDest), 32'(e.dest));
        checkField("outAluOp", 32'(outAluOp), 32'(e.aluOp));
        checkField("outAluSrc", 32'(outAluSrc), 32'(e.aluSrc));
        checkField("outBranch", 32'(outBranch), 32'(e.branch));
        checkField("outNotZero", 32'(outNotZero), 32'(e.notZero));
        checkField("outJump", 32'(outJump), 32'(e.jump));
        checkField("outMemRead", 32'(outMemRead), 32'(e.memRead));
        checkField("outMemWrite", 32'(outMemWrite), 32'(e.memWrite));
        checkField("outMemToReg", 32'(outMemToReg), 32'(e.memToReg));
        checkField("outRegWrite", 32'(outRegWrite), 32'(e.regWrite));
        checkField("outIllegal", 32'(outIllegal), 32'(e.illegal));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Cycle model sampled between the falling and the next rising edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic modelStep(output logic accepted);
        logic idExReadyM;
        logic inReadyM;
        idExReadyM = !idExValidM || outReady;
        inReadyM   = !ifIdValidM || idExReadyM;
        checkField("outValid", 32'(outValid), 32'(idExValidM));
        checkField("inReady", 32'(inReady), 32'(inReadyM));
        if (idExValidM && outReady) begin
            if (expQueue.size() == 0) reportFailure("Output transfer with nothing expected");
            comparePacket(expQueue.pop_front());
            recvCount++;
        end
        // Write lands on the coming edge and the capture sees it through the bypass
        if (wbRegWrite && wbDest != 5'd0) modelRegs[wbDest] = wbData;
        if (ifIdValidM && idExReadyM) expQueue.push_back(modelDecode(ifIdInstrM, ifIdPcM));
        if (idExReadyM) idExValidM = ifIdValidM;
        accepted = inValid && inReadyM;
        if (accepted) begin
            ifIdValidM = 1'b1;
            ifIdInstrM = inInstruction;
            ifIdPcM    = inPc;
            sentCount++;
        end else if (inReadyM) begin
            ifIdValidM = 1'b0;
        end
    endtask

    task automatic runCycle(input logic valid, input logic [31:0] instr,
                            input logic [31:0] pc, input logic ready, input logic wbEn,
                            input logic [4:0] wbAddr, input logic [31:0] wbVal,
                            output logic accepted);
        @(negedge Clk);
        inValid       = valid;
        inInstruction = instr;
        inPc          = pc;
        outReady      = ready;
        wbRegWrite    = wbEn;
        wbDest        = wbAddr;
        wbData        = wbVal;
        #1;
        modelStep(accepted);
    endtask

    // Valid is held once raised until the stage takes the instruction
    task automatic sendInstr(input logic [31:0] instr, input logic [31:0] pc,
                             input logic jitter);
        logic accepted;
        logic valid;
        logic ready;
        int   waitCycles;
        accepted   = 1'b0;
        valid      = 1'b0;
        waitCycles = 0;
        while (!accepted) begin
            if (!valid) valid = jitter ? ($urandom_range(0, 3) != 0) : 1'b1;
            ready = jitter ? ($urandom_range(0, 1) == 1) : 1'b1;
            runCycle(valid, instr, pc, ready, 1'b0, 5'd0, 32'd0, accepted);
            waitCycles++;
            if (waitCycles > 100) reportFailure("Timeout waiting for inReady");
        end
    endtask

    task automatic writeback(input logic [4:0] addr, input logic [31:0] data);
        logic accepted;
        runCycle(1'b0, 32'd0, 32'd0, 1'b1, 1'b1, addr, data, accepted);
    endtask

    task automatic drainPipe();
        logic accepted;
        int   waitCycles;
        waitCycles = 0;
        while (ifIdValidM || idExValidM) begin
            runCycle(1'b0, 32'd0, 32'd0, 1'b1, 1'b0, 5'd0, 32'd0, accepted);
            waitCycles++;
            if (waitCycles > 20) reportFailure("Timeout waiting for the pipeline to drain");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        logic [4:0]  src;
        logic [5:0]  opList [12];
        logic [5:0]  fnList [9];
        logic        idleAccepted;
        void'($urandom(32'h5b42));
        opList = '{opJ, opJal, opBeq, opBne, opAddiu, opSlti, opAndi, opOri, opXori,
                   opLui, opLw, opSw};
        fnList = '{fnSll, fnSrl, fnJr, fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt};
        foreach (modelRegs[i]) modelRegs[i] = 32'd0;
        ifIdValidM    = 1'b0;
        ifIdInstrM    = 32'd0;
        ifIdPcM       = 32'd0;
        idExValidM    = 1'b0;
        sentCount     = 0;
        recvCount     = 0;
        rstN          = 1'b0;
        inValid       = 1'b0;
        inInstruction = 32'd0;
        inPc          = 32'd0;
        outReady      = 1'b0;
        wbRegWrite    = 1'b0;
        wbDest        = 5'd0;
        wbData        = 32'd0;
        repeat (10) @(negedge Clk);
        rstN = 1'b1;

        // Cleared registers and then register 0 ignoring a write
        sendInstr({opRType, 5'd1, 5'd2, 5'd3, 5'd0, fnAddu}, 32'h0040_0000, 1'b0);
        drainPipe();
        writeback(5'd0, $urandom());
        sendInstr({opRType, 5'd0, 5'd0, 5'd3, 5'd0, fnOr}, 32'h0040_0004, 1'b0);
        drainPipe();

        for (int r = 1; r < 32; r++) begin
            writeback(5'(r), $urandom());
            rnd = $urandom();
            sendInstr({opRType, 5'(r), rnd[20:11], 5'd0, fnSubu}, $urandom(), 1'b0);
            drainPipe();
        end

        // Whole decode table back to back with bit 15 of each immediate set
        foreach (fnList[i]) begin
            rnd = $urandom();
            sendInstr({opRType, rnd[25:6], fnList[i]}, $urandom(), 1'b0);
        end
        foreach (opList[i]) begin
            rnd = $urandom() | 32'h0000_8000;
            sendInstr({opList[i], rnd[25:0]}, $urandom(), 1'b0);
        end
        repeat (10) begin
            rnd = $urandom();
            sendInstr({2'b11, rnd[29:0]}, $urandom(), 1'b0);
            sendInstr({opRType, rnd[25:6], 2'b11, rnd[3:0]}, $urandom(), 1'b0);
        end
        drainPipe();

        // Writeback one cycle after acceptance reaches the captured operands
        repeat (8) begin
            src = 5'($urandom_range(1, 31));
            sendInstr({opRType, src, src, 5'd4, 5'd0, fnAddu}, $urandom(), 1'b0);
            writeback(src, $urandom());
            drainPipe();
        end

        for (int i = 0; i < 300; i++) begin
            rnd = $urandom();
            if (i % 3 == 0) sendInstr({opRType, rnd[25:6], fnList[i % 9]}, $urandom(), 1'b1);
            else sendInstr({opList[i % 12], rnd[25:0]}, $urandom(), 1'b1);
        end
        drainPipe();

        // The last drain reaches the outputs one edge later
        runCycle(1'b0, 32'd0, 32'd0, 1'b1, 1'b0, 5'd0, 32'd0, idleAccepted);

        if (expQueue.size() != 0 || sentCount != recvCount) begin
            reportFailure("Instructions lost or duplicated between input and output");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/decodeStage_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStageAssert (
    input wire                               Clk,
    input wire                               rstN,
    input wire                               inReady,
    input wire                               outValid,
    input wire                               outReady,
    input wire [decodePkg::dataWidth-1:0]    outPc,
    input wire [decodePkg::dataWidth-1:0]    outJumpTarget,
    input wire [decodePkg::dataWidth-1:0]    outReadData1,
    input wire [decodePkg::dataWidth-1:0]    outReadData2,
    input wire [decodePkg::dataWidth-1:0]    outImmediate,
    input wire [4:0]                         outShamt,
    input wire [decodePkg::regAddrWidth-1:0] outDest,
    input wire decodePkg::aluOpT             outAluOp,
    input wire                               outAluSrc,
    input wire                               outBranch,
    input wire                               outNotZero,
    input wire decodePkg::jumpT              outJump,
    input wire                               outMemRead,
    input wire                               outMemWrite,
    input wire                               outMemToReg,
    input wire                               outRegWrite,
    input wire                               outIllegal
);

    // Nothing offered right after reset
    assert property (@(posedge Clk) $rose(rstN) |-> !outValid)
        else $error("outValid high in the cycle after reset release");

    // Held packet under back-pressure
    assert property (@(posedge Clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outPc) && $stable(outJumpTarget)
            && $stable(outReadData1) && $stable(outReadData2) && $stable(outImmediate)
            && $stable(outShamt) && $stable(outDest) && $stable(outAluOp)
            && $stable(outAluSrc) && $stable(outBranch) && $stable(outNotZero)
            && $stable(outJump) && $stable(outMemRead) && $stable(outMemWrite)
            && $stable(outMemToReg) && $stable(outRegWrite) && $stable(outIllegal))
        else $error("Output changed while stalled by outReady");

    // Empty ID/EX always frees the input side
    assert property (@(posedge Clk) disable iff (!rstN) !outValid |-> inReady)
        else $error("inReady low while outValid is low");

endmodule

bind decodeStage decodeStageAssert decodeChecks (
    .Clk           (Clk),
    .rstN          (rstN),
    .inReady       (inReady),
    .outValid      (outValid),
    .outReady      (outReady),
    .outPc         (outPc),
    .outJumpTarget (outJumpTarget),
    .outReadData1  (outReadData1),
    .outReadData2  (outReadData2),
    .outImmediate  (outImmediate),
    .outShamt      (outShamt),
    .outDest       (outDest),
    .outAluOp      (outAluOp),
    .outAluSrc     (outAluSrc),
    .outBranch     (outBranch),
    .outNotZero    (outNotZero),
    .outJump       (outJump),
    .outMemRead    (outMemRead),
    .outMemWrite   (outMemWrite),
    .outMemToReg   (outMemToReg),
    .outRegWrite   (outRegWrite),
    .outIllegal    (outIllegal)
);

`default_nettype wire

// ==== hw/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  wire                                Clk,
    input  wire                                rstN,
    // Fetch side
    input  wire                                inValid,
    input  wire [decodePkg::dataWidth-1:0]     inInstruction,
    input  wire [decodePkg::dataWidth-1:0]     inPc,
    output logic                               inReady,
    // Writeback
    input  wire                                wbRegWrite,
    input  wire [decodePkg::regAddrWidth-1:0]  wbDest,
    input  wire [decodePkg::dataWidth-1:0]     wbData,
    // Execute side
    input  wire                                outReady,
    output logic                               outValid,
    output logic [decodePkg::dataWidth-1:0]    outPc,
    output logic [decodePkg::dataWidth-1:0]    outJumpTarget,
    output logic [decodePkg::dataWidth-1:0]    outReadData1,
    output logic [decodePkg::dataWidth-1:0]    outReadData2,
    output logic [decodePkg::dataWidth-1:0]    outImmediate,
    output logic [4:0]                         outShamt,
    output logic [decodePkg::regAddrWidth-1:0] outDest,
    output decodePkg::aluOpT                   outAluOp,
    output logic                               outAluSrc,
    output logic                               outBranch,
    output logic                               outNotZero,
    output decodePkg::jumpT                    outJump,
    output logic                               outMemRead,
    output logic                               outMemWrite,
    output logic                               outMemToReg,
    output logic                               outRegWrite,
    output logic                               outIllegal
);

    import decodePkg::*;

    fetchPacketT  fetchIn;
    fetchPacketT  fetchPacket;
    decodePacketT decodedPacket;
    decodePacketT execPacket;
    logic         fetchValid;
    logic         idExReady;

    assign fetchIn.instruction = inInstruction;
    assign fetchIn.pc          = inPc;

    ////////////////////////////////////////////////////////////////////////////
    // IF/ID, decode, ID/EX
    ////////////////////////////////////////////////////////////////////////////

    pipeStage #(.payloadT(fetchPacketT)) ifIdStage (
        .Clk       (Clk),
        .rstN      (rstN),
        .upValid   (inValid),
        .upData    (fetchIn),
        .downReady (idExReady),
        .upReady   (inReady),
        .downValid (fetchValid),
        .downData  (fetchPacket)
    );

    instructionDecodeUnit decodeUnit (
        .Clk         (Clk),
        .rstN        (rstN),
        .instruction (fetchPacket.instruction),
        .pc          (fetchPacket.pc),
        .wbRegWrite  (wbRegWrite),
        .wbDest      (wbDest),
        .wbData      (wbData),
        .decoded     (decodedPacket)
    );

    pipeStage #(.payloadT(decodePacketT)) idExStage (
        .Clk       (Clk),
        .rstN      (rstN),
        .upValid   (fetchValid),
        .upData    (decodedPacket),
        .downReady (outReady),
        .upReady   (idExReady),
        .downValid (outValid),
        .downData  (execPacket)
    );

    // Unpack onto the execute interface
    assign outPc         = execPacket.pc;
    assign outJumpTarget = execPacket.jumpTarget;
    assign outReadData1  = execPacket.readData1;
    assign outReadData2  = execPacket.readData2;
    assign outImmediate  = execPacket.immediate;
    assign outShamt      = execPacket.shamt;
    assign outDest       = execPacket.dest;
    assign outAluOp      = execPacket.aluOp;
    assign outAluSrc     = execPacket.aluSrc;
    assign outBranch     = execPacket.branch;
    assign outNotZero    = execPacket.notZero;
    assign outJump       = execPacket.jump;
    assign outMemRead    = execPacket.memRead;
    assign outMemWrite   = execPacket.memWrite;
    assign outMemToReg   = execPacket.memToReg;
    assign outRegWrite   = execPacket.regWrite;
    assign outIllegal    = execPacket.illegal;

endmodule

`default_nettype wire

// ==== hw/instructionDecodeUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecodeUnit (
    input  wire                               Clk,
    input  wire                               rstN,
    input  wire [decodePkg::dataWidth-1:0]    instruction,
    input  wire [decodePkg::dataWidth-1:0]    pc,
    input  wire                               wbRegWrite,
    input  wire [decodePkg::regAddrWidth-1:0] wbDest,
    input  wire [decodePkg::dataWidth-1:0]    wbData,
    output decodePkg::decodePacketT           decoded
);

    import decodePkg::*;

    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [15:0]             imm16;
    logic [dataWidth-1:0]    regData1;
    logic [dataWidth-1:0]    regData2;
    logic [regAddrWidth-1:0] destSel;
    aluOpT                   aluOp;
    jumpT                    jump;
    logic aluSrc, branch, notZero, memRead, memWrite, memToReg, regWrite;
    logic zeroExtend, destRd, destLink, illegal;

    // Writeback hits a source register this cycle
    function automatic logic wbHits(input logic [regAddrWidth-1:0] srcAddr);
        return wbRegWrite && (wbDest != '0) && (wbDest == srcAddr);
    endfunction

    // Instruction fields
    assign rs    = instruction[25:21];
    assign rt    = instruction[20:16];
    assign rd    = instruction[15:11];
    assign imm16 = instruction[15:0];

    registerFile regFile (
        .Clk         (Clk),
        .rstN        (rstN),
        .readAddr1   (rs),
        .readAddr2   (rt),
        .writeEnable (wbRegWrite),
        .writeAddr   (wbDest),
        .writeData   (wbData),
        .readData1   (regData1),
        .readData2   (regData2)
    );

    controller ctrl (
        .opcode     (instruction[31:26]),
        .funct      (instruction[5:0]),
        .aluOp      (aluOp),
        .jump       (jump),
        .aluSrc     (aluSrc),
        .branch     (branch),
        .notZero    (notZero),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .memToReg   (memToReg),
        .regWrite   (regWrite),
        .zeroExtend (zeroExtend),
        .destRd     (destRd),
        .destLink   (destLink),
        .illegal    (illegal)
    );

    // Destination, 0 when nothing is written
    always_comb begin
        if (!regWrite) begin
            destSel = '0;
        end else if (destLink) begin
            destSel = linkReg;
        end else if (destRd) begin
            destSel = rd;
        end else begin
            destSel = rt;
        end
    end

    always_comb begin
        decoded.pc         = pc;
        decoded.jumpTarget = {pc[31:28], instruction[25:0], 2'b00};
        decoded.readData1  = wbHits(rs) ? wbData : regData1;
        decoded.readData2  = wbHits(rt) ? wbData : regData2;
        // LUI takes the raw field too, execute does the shift
        decoded.immediate  = zeroExtend ? {{(dataWidth-16){1'b0}}, imm16}
                                        : {{(dataWidth-16){imm16[15]}}, imm16};
        decoded.shamt      = instruction[10:6];
        decoded.dest       = destSel;
        decoded.aluOp      = aluOp;
        decoded.aluSrc     = aluSrc;
        decoded.branch     = branch;
        decoded.notZero    = notZero;
        decoded.jump       = jump;
        decoded.memRead    = memRead;
        decoded.memWrite   = memWrite;
        decoded.memToReg   = memToReg;
        decoded.regWrite   = regWrite;
        decoded.illegal    = illegal;
    end

endmodule

`default_nettype wire

// ==== hw/controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module controller (
    input  wire [5:0]        opcode,
    input  wire [5:0]        funct,
    output decodePkg::aluOpT aluOp,
    output decodePkg::jumpT  jump,
    output logic             aluSrc,
    output logic             branch,
    output logic             notZero,
    output logic             memRead,
    output logic             memWrite,
    output logic             memToReg,
    output logic             regWrite,
    output logic             zeroExtend,
    output logic             destRd,
    output logic             destLink,
    output logic             illegal
);

    import decodePkg::*;

    always_comb begin
        // Everything inactive unless the encoding is recognised
        aluOp      = aluAdd;
        jump       = jumpNone;
        aluSrc     = 1'b0;
        branch     = 1'b0;
        notZero    = 1'b0;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        memToReg   = 1'b0;
        regWrite   = 1'b0;
        zeroExtend = 1'b0;
        destRd     = 1'b0;
        destLink   = 1'b0;
        illegal    = 1'b0;

        case (opcode)
            opRType: begin
                // ALU functions write rd
                regWrite = 1'b1;
                destRd   = 1'b1;
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSll:  aluOp = aluSll;
                    fnSrl:  aluOp = aluSrl;
                    fnJr: begin
                        regWrite = 1'b0;
                        destRd   = 1'b0;
                        jump     = jumpReg;
                    end
                    default: begin
                        regWrite = 1'b0;
                        destRd   = 1'b0;
                        illegal  = 1'b1;
                    end
                endcase
            end

            // Immediate ALU group, result to rt
            opAddiu: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            opSlti: begin
                aluOp    = aluSlt;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            opAndi: begin
                aluOp      = aluAnd;
                aluSrc     = 1'b1;
                regWrite   = 1'b1;
                zeroExtend = 1'b1;
            end
            opOri: begin
                aluOp      = aluOr;
                aluSrc     = 1'b1;
                regWrite   = 1'b1;
                zeroExtend = 1'b1;
            end
            opXori: begin
                aluOp      = aluXor;
                aluSrc     = 1'b1;
                regWrite   = 1'b1;
                zeroExtend = 1'b1;
            end
            opLui: begin
                aluOp      = aluLui;
                aluSrc     = 1'b1;
                regWrite   = 1'b1;
                zeroExtend = 1'b1;
            end

            // Memory, address is base plus offset
            opLw: begin
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                regWrite = 1'b1;
            end
            opSw: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end

            // Branches compare by subtraction
            opBeq: begin
                aluOp  = aluSub;
                branch = 1'b1;
            end
            opBne: begin
                aluOp   = aluSub;
                branch  = 1'b1;
                notZero = 1'b1;
            end

            opJ: begin
                jump = jumpDirect;
            end
            opJal: begin
                jump     = jumpDirect;
                regWrite = 1'b1;
                destLink = 1'b1;
            end

            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire                                 Clk,
    input  wire                                 rstN,
    input  wire [decodePkg::regAddrWidth-1:0]   readAddr1,
    input  wire [decodePkg::regAddrWidth-1:0]   readAddr2,
    input  wire                                 writeEnable,
    input  wire [decodePkg::regAddrWidth-1:0]   writeAddr,
    input  wire [decodePkg::dataWidth-1:0]      writeData,
    output logic [decodePkg::dataWidth-1:0]     readData1,
    output logic [decodePkg::dataWidth-1:0]     readData2
);

    import decodePkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    // Write port, register 0 never written
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Combinational read ports
    assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

// ==== hw/pipeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
    parameter type payloadT = logic
) (
    input  wire          Clk,
    input  wire          rstN,
    input  wire          upValid,
    input  wire payloadT upData,
    input  wire          downReady,
    output logic         upReady,
    output logic         downValid,
    output payloadT      downData
);

    logic    validQ;
    payloadT dataQ;

    // Free slot, or the held entry leaves this cycle
    assign upReady   = !validQ || downReady;
    assign downValid = validQ;
    assign downData  = dataQ;

    // Occupancy follows upValid whenever the slot can take a new entry
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else if (upReady) begin
            validQ <= upValid;
        end
    end

    // Payload changes only on an upstream transfer
    always_ff @(posedge Clk) begin
        if (upValid && upReady) begin
            dataQ <= upData;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decodePkg.sv ====
`default_nettype none

package decodePkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and fixed registers
    ////////////////////////////////////////////////////////////////////////////

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs      = 32;

    // JAL writes its return address here
    localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////////////////////

    // Primary opcodes, instruction bits 31:26
    localparam logic [5:0] opRType = 6'b000000;
    localparam logic [5:0] opJ     = 6'b000010;
    localparam logic [5:0] opJal   = 6'b000011;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opBne   = 6'b000101;
    localparam logic [5:0] opAddiu = 6'b001001;
    localparam logic [5:0] opSlti  = 6'b001010;
    localparam logic [5:0] opAndi  = 6'b001100;
    localparam logic [5:0] opOri   = 6'b001101;
    localparam logic [5:0] opXori  = 6'b001110;
    localparam logic [5:0] opLui   = 6'b001111;
    localparam logic [5:0] opLw    = 6'b100011;
    localparam logic [5:0] opSw    = 6'b101011;

    // R-type function codes, bits 5:0
    localparam logic [5:0] fnSll  = 6'b000000;
    localparam logic [5:0] fnSrl  = 6'b000010;
    localparam logic [5:0] fnJr   = 6'b001000;
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnSlt  = 6'b101010;

    ////////////////////////////////////////////////////////////////////////////
    // Decode results and pipeline payloads
    ////////////////////////////////////////////////////////////////////////////

    // Operation performed by execute
    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluSrl,
        aluLui
    } aluOpT;

    // Next-PC selection
    typedef enum logic [1:0] {
        jumpNone   = 2'd0,
        jumpDirect = 2'd1,
        jumpReg    = 2'd2
    } jumpT;

    // IF/ID payload
    typedef struct packed {
        logic [dataWidth-1:0] instruction;
        logic [dataWidth-1:0] pc;
    } fetchPacketT;

    // ID/EX payload
    typedef struct packed {
        logic [dataWidth-1:0]    pc;
        logic [dataWidth-1:0]    jumpTarget;
        logic [dataWidth-1:0]    readData1;
        logic [dataWidth-1:0]    readData2;
        logic [dataWidth-1:0]    immediate;
        logic [4:0]              shamt;
        logic [regAddrWidth-1:0] dest;
        aluOpT                   aluOp;
        logic                    aluSrc;
        logic                    branch;
        logic                    notZero;
        jumpT                    jump;
        logic                    memRead;
        logic                    memWrite;
        logic                    memToReg;
        logic                    regWrite;
        logic                    illegal;
    } decodePacketT;

endpackage

`default_nettype wire
